/* Makefile */
TOP := tb_if_stage

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f if_stage.f
	./obj_dir/V$(TOP) | awk '{ print } /^\*\* PASS \*\*$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* hw/fetch_buffer.sv */
// Fetched word FIFO
`default_nettype none

module fetch_buffer (
  input  wire                     clk,
  input  wire                     rst_n,
  input  logic                    flush_i,
  input  logic                    push_i,
  input  fetch_pkg::fetch_entry_t push_entry_i,
  input  logic                    pop_i,
  output fetch_pkg::fetch_entry_t head_o,
  output logic                    word_valid_o,
  output logic                    room_o
);
  import fetch_pkg::*;

  fetch_entry_t                     mem_q [FETCH_DEPTH];
  logic [$clog2(FETCH_DEPTH)-1:0]   wptr_q;
  logic [$clog2(FETCH_DEPTH)-1:0]   rptr_q;
  logic [$clog2(FETCH_DEPTH+1)-1:0] cnt_q;
  logic                             do_pop;

  // Pointer wrap for a depth that is not a power of two
  function automatic logic [$clog2(FETCH_DEPTH)-1:0] ptr_inc(
    input logic [$clog2(FETCH_DEPTH)-1:0] ptr
  );
    if (ptr == FETCH_DEPTH - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_pop = pop_i && word_valid_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      // Redirect empties the buffer
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push_i) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (do_pop) begin
        rptr_q <= ptr_inc(rptr_q);
      end
      case ({push_i, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem_q[wptr_q] <= push_entry_i;
    end
  end

  assign head_o       = mem_q[rptr_q];
  assign word_valid_o = (cnt_q != '0);
  // Master only asks with no read open so one free slot covers it
  assign room_o       = (cnt_q < FETCH_DEPTH);

endmodule

`default_nettype wire

/* hw/fetch_pkg.sv */
// Instruction fetch types
// PC targets, control and pipeline records
`default_nettype none

package fetch_pkg;

  // Word buffer depth covering one read in flight plus the held word
  localparam int unsigned FETCH_DEPTH  = 3;
  // mtvec base is aligned to 128 bytes
  localparam int unsigned MTVEC_BASE_W = 25;
  localparam int unsigned IRQ_INDEX_W  = 5;

  // Next PC sources
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  // Request from the core controller
  typedef struct packed {
    logic                   pc_set;
    pc_mux_e                pc_mux;
    logic                   kill_if;
    logic                   halt_if;
    logic [IRQ_INDEX_W-1:0] irq_index;
  } fetch_ctrl_t;

  ////////////////////////////////////////
  // Fetched word views
  ////////////////////////////////////////

  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } parcel_pair_t;

  // Full word, or two halfword parcels
  typedef union packed {
    logic [31:0]  word;
    parcel_pair_t parcel;
  } fetch_word_u;

  typedef struct packed {
    fetch_word_u data;
    logic        err;
  } fetch_entry_t;

  // One instruction cut out of the word stream
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        compressed;
    logic        err;
  } aligned_instr_t;

  // IF/ID stage register contents
  typedef struct packed {
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        compressed;
    logic        abort_op;
  } if_id_pipe_t;

endpackage

`default_nettype wire

/* hw/if_ctrl.sv */
// Fetch control and next PC select
`default_nettype none

module if_ctrl (
  input  wire                                clk,
  input  wire                                rst_n,
  input  fetch_pkg::fetch_ctrl_t             ctrl_i,
  input  logic [31:0]                        boot_addr_i,
  input  logic [31:0]                        jump_target_i,
  input  logic [31:0]                        branch_target_i,
  input  logic [31:0]                        mepc_i,
  input  logic [fetch_pkg::MTVEC_BASE_W-1:0] mtvec_addr_i,
  input  logic                               instr_valid_i,
  input  logic                               id_ready_i,
  output logic                               restart_o,
  output logic [31:0]                        restart_addr_o,
  output logic                               if_valid_o,
  output logic                               advance_o,
  output logic                               capture_o,
  output logic                               csr_mtvec_init_o
);
  import fetch_pkg::*;

  logic [IRQ_INDEX_W-1:0] irq_idx;
  logic [31:0]            target;
  logic                   restart_q;
  logic [31:0]            restart_addr_q;

  assign irq_idx = ctrl_i.irq_index;

  ////////////////////////////////////////
  // Next PC selection
  ////////////////////////////////////////

  always_comb begin
    // Boot address is word aligned
    target = {boot_addr_i[31:2], 2'b00};
    unique case (ctrl_i.pc_mux)
      PC_BOOT:     target = {boot_addr_i[31:2], 2'b00};
      PC_JUMP:     target = jump_target_i;
      PC_BRANCH:   target = branch_target_i;
      PC_MRET:     target = mepc_i;
      // Exceptions share the base
      PC_TRAP_EXC: target = {mtvec_addr_i, 7'h00};
      // Vectored interrupts at base plus 4 x index
      PC_TRAP_IRQ: target = {mtvec_addr_i, irq_idx, 2'b00};
      default: ;
    endcase
  end

  // Restart strobe lands one cycle after pc_set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      restart_q <= 1'b0;
    end else begin
      restart_q <= ctrl_i.pc_set;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_i.pc_set) begin
      // Halfword aligned target
      restart_addr_q <= {target[31:1], 1'b0};
    end
  end

  assign restart_o      = restart_q;
  assign restart_addr_o = restart_addr_q;

  // mtvec init request on boot
  assign csr_mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == PC_BOOT);

  ////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////

  // Hidden while a redirect is on its way so no stale instruction leaks
  assign if_valid_o = instr_valid_i && !ctrl_i.halt_if && !ctrl_i.kill_if &&
                      !ctrl_i.pc_set && !restart_q;

  // Kill drains the aligner without a capture
  assign advance_o = (if_valid_o && id_ready_i) || ctrl_i.kill_if;
  assign capture_o = advance_o && !ctrl_i.kill_if;

endmodule

`default_nettype wire

/* hw/if_id_reg.sv */
// IF/ID pipeline register
`default_nettype none

module if_id_reg (
  input  wire                       clk,
  input  wire                       rst_n,
  input  logic                      capture_i,
  input  logic                      id_ready_i,
  input  fetch_pkg::aligned_instr_t instr_i,
  output fetch_pkg::if_id_pipe_t    if_id_pipe_o
);
  import fetch_pkg::*;

  logic           valid_q;
  aligned_instr_t instr_q;

  // Bubble when ID takes nothing new, hold while ID stalls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (capture_i) begin
      valid_q <= 1'b1;
    end else if (id_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture_i) begin
      instr_q <= instr_i;
    end
  end

  // Bus error becomes the abort flag
  assign if_id_pipe_o = '{
    instr_valid: valid_q,
    instr:       instr_q.instr,
    pc:          instr_q.pc,
    compressed:  instr_q.compressed,
    abort_op:    instr_q.err
  };

endmodule

`default_nettype wire

/* hw/if_stage.sv */
// Instruction fetch stage top
`default_nettype none

module if_stage (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  logic [31:0]                           boot_addr_i,
  input  logic [31:0]                           jump_target_i,
  input  logic [31:0]                           branch_target_i,
  input  logic [31:0]                           mepc_i,
  input  logic [fetch_pkg::MTVEC_BASE_W-1:0]    mtvec_addr_i,
  input  fetch_pkg::fetch_ctrl_t                ctrl_i,
  input  logic                                  id_ready_i,
  input  wb_pkg::wb_rsp_t                       wb_rsp_i,
  output wb_pkg::wb_req_t                       wb_req_o,
  output fetch_pkg::if_id_pipe_t                if_id_pipe_o,
  output logic [31:0]                           pc_if_o,
  output logic                                  if_valid_o,
  output logic                                  if_busy_o,
  output logic                                  csr_mtvec_init_o
);
  import fetch_pkg::*;

  // Redirect from control to the datapath
  logic           restart;
  logic [31:0]    restart_addr;

  // Bus master to buffer
  logic           room;
  logic           push;
  fetch_entry_t   push_entry;

  // Buffer to aligner
  fetch_entry_t   head;
  logic           word_valid;
  logic           word_pop;

  // Aligner to control and IF/ID register
  aligned_instr_t aligned;
  logic           instr_valid;
  logic           advance;
  logic           capture;

  if_ctrl if_ctrl_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_i           (ctrl_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .instr_valid_i    (instr_valid),
    .id_ready_i       (id_ready_i),
    .restart_o        (restart),
    .restart_addr_o   (restart_addr),
    .if_valid_o       (if_valid_o),
    .advance_o        (advance),
    .capture_o        (capture),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  wb_fetch_master wb_fetch_master_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .restart_i      (restart),
    .restart_addr_i (restart_addr),
    .room_i         (room),
    .wb_rsp_i       (wb_rsp_i),
    .wb_req_o       (wb_req_o),
    .push_o         (push),
    .push_entry_o   (push_entry),
    .busy_o         (if_busy_o)
  );

  fetch_buffer fetch_buffer_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (restart),
    .push_i       (push),
    .push_entry_i (push_entry),
    .pop_i        (word_pop),
    .head_o       (head),
    .word_valid_o (word_valid),
    .room_o       (room)
  );

  instr_aligner instr_aligner_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .restart_i      (restart),
    .restart_addr_i (restart_addr),
    .head_i         (head),
    .word_valid_i   (word_valid),
    .advance_i      (advance),
    .word_pop_o     (word_pop),
    .instr_o        (aligned),
    .instr_valid_o  (instr_valid),
    .pc_o           (pc_if_o)
  );

  if_id_reg if_id_reg_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .capture_i    (capture),
    .id_ready_i   (id_ready_i),
    .instr_i      (aligned),
    .if_id_pipe_o (if_id_pipe_o)
  );

endmodule

`default_nettype wire

/* hw/instr_aligner.sv */
// Instruction aligner
// Cuts 16 and 32 bit instructions out of fetched words
`default_nettype none

module instr_aligner (
  input  wire                       clk,
  input  wire                       rst_n,
  input  logic                      restart_i,
  input  logic [31:0]               restart_addr_i,
  input  fetch_pkg::fetch_entry_t   head_i,
  input  logic                      word_valid_i,
  input  logic                      advance_i,
  output logic                      word_pop_o,
  output fetch_pkg::aligned_instr_t instr_o,
  output logic                      instr_valid_o,
  output logic [31:0]               pc_o
);

  logic [31:0] pc_q;
  // Next parcel is the upper half of the head word
  logic        hi_sel_q;
  // Lower half of a straddling instruction is held
  logic        held_q;
  logic [15:0] held_parcel_q;
  logic        held_err_q;

  logic [15:0] lo_parcel;
  logic [15:0] hi_parcel;
  logic        lo_is_c;
  logic        hi_is_c;
  logic        consume;
  logic        straddle_grab;

  assign lo_parcel = head_i.data.parcel.lo;
  assign hi_parcel = head_i.data.parcel.hi;
  // Low bits 11 mark a 32 bit instruction
  assign lo_is_c   = (lo_parcel[1:0] != 2'b11);
  assign hi_is_c   = (hi_parcel[1:0] != 2'b11);

  ////////////////////////////////////////
  // Instruction select
  ////////////////////////////////////////

  always_comb begin
    instr_o.pc         = pc_q;
    instr_o.instr      = head_i.data.word;
    instr_o.compressed = 1'b0;
    instr_o.err        = head_i.err;
    instr_valid_o      = 1'b0;
    if (held_q) begin
      // Straddler whose upper half is the low parcel of the new word
      instr_o.instr = {lo_parcel, held_parcel_q};
      instr_o.err   = held_err_q | head_i.err;
      instr_valid_o = word_valid_i;
    end else if (!hi_sel_q) begin
      if (lo_is_c) begin
        instr_o.instr      = {16'h0000, lo_parcel};
        instr_o.compressed = 1'b1;
      end
      instr_valid_o = word_valid_i;
    end else if (hi_is_c) begin
      instr_o.instr      = {16'h0000, hi_parcel};
      instr_o.compressed = 1'b1;
      instr_valid_o      = word_valid_i;
    end
  end

  assign consume       = advance_i && instr_valid_o;
  // 32 bit instruction in the upper half waits for the next word
  assign straddle_grab = word_valid_i && !held_q && hi_sel_q && !hi_is_c;

  // Pop once the last parcel of the head word is used
  assign word_pop_o = !restart_i &&
                      (straddle_grab || (consume && !held_q && (hi_sel_q || !lo_is_c)));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q     <= '0;
      hi_sel_q <= 1'b0;
      held_q   <= 1'b0;
    end else if (restart_i) begin
      pc_q     <= {restart_addr_i[31:1], 1'b0};
      hi_sel_q <= restart_addr_i[1];
      held_q   <= 1'b0;
    end else if (straddle_grab) begin
      held_q   <= 1'b1;
      hi_sel_q <= 1'b0;
    end else if (consume) begin
      pc_q     <= pc_q + (instr_o.compressed ? 32'd2 : 32'd4);
      held_q   <= 1'b0;
      // Upper half follows a straddler or a compressed lower half
      hi_sel_q <= held_q | (!hi_sel_q & instr_o.compressed);
    end
  end

  always_ff @(posedge clk) begin
    if (straddle_grab) begin
      held_parcel_q <= hi_parcel;
      held_err_q    <= head_i.err;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

/* hw/wb_fetch_master.sv */
// Wishbone classic fetch master
`default_nettype none

module wb_fetch_master (
  input  wire                     clk,
  input  wire                     rst_n,
  input  logic                    restart_i,
  input  logic [31:0]             restart_addr_i,
  input  logic                    room_i,
  input  wb_pkg::wb_rsp_t         wb_rsp_i,
  output wb_pkg::wb_req_t         wb_req_o,
  output logic                    push_o,
  output fetch_pkg::fetch_entry_t push_entry_o,
  output logic                    busy_o
);
  import wb_pkg::*;

  logic [WB_ADDR_W-1:0] addr_q;
  // Address of the open cycle, frozen until the slave answers
  logic [WB_ADDR_W-1:0] adr_q;
  logic                 cyc_q;
  // Response of the open cycle belongs to a killed stream
  logic                 drop_q;
  // Set by the first restart
  logic                 active_q;
  logic                 bus_done;
  logic                 start;

  // Slave ends the cycle with ack or err
  assign bus_done = cyc_q && (wb_rsp_i.ack || wb_rsp_i.err);
  assign start    = !cyc_q && (restart_i || (active_q && room_i));

  ////////////////////////////////////////
  // Cycle control
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_q    <= 1'b0;
      drop_q   <= 1'b0;
      active_q <= 1'b0;
    end else begin
      if (restart_i) begin
        active_q <= 1'b1;
      end
      if (cyc_q) begin
        // Hold cyc and stb until the slave answers
        if (bus_done) begin
          cyc_q  <= 1'b0;
          drop_q <= 1'b0;
        end else if (restart_i) begin
          drop_q <= 1'b1;
        end
      end else if (start) begin
        // Idle for at least one cycle between reads
        cyc_q <= 1'b1;
      end
    end
  end

  // Word aligned address of the next read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (restart_i) begin
      addr_q <= {restart_addr_i[31:2], 2'b00};
    end else if (bus_done && !drop_q) begin
      addr_q <= addr_q + 32'd4;
    end
  end

  // Bus address only moves when a new cycle opens
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      adr_q <= '0;
    end else if (start) begin
      adr_q <= restart_i ? {restart_addr_i[31:2], 2'b00} : addr_q;
    end
  end

  // Single read on all byte lanes
  assign wb_req_o = '{cyc: cyc_q, stb: cyc_q, we: 1'b0, sel: 4'hF, adr: adr_q};

  // Push in the ack cycle unless the stream was redirected
  assign push_o = bus_done && !drop_q && !restart_i;

  always_comb begin
    push_entry_o.data.word = wb_rsp_i.dat;
    push_entry_o.err       = wb_rsp_i.err;
  end

  assign busy_o = cyc_q;

endmodule

`default_nettype wire

/* hw/wb_pkg.sv */
// Wishbone classic bus types
`default_nettype none

package wb_pkg;

  localparam int unsigned WB_ADDR_W = 32;
  localparam int unsigned WB_DATA_W = 32;

  // Master to slave
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [3:0]           sel;
    logic [WB_ADDR_W-1:0] adr;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic                 ack;
    logic                 err;
    logic [WB_DATA_W-1:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

/* if_stage.f */
hw/fetch_pkg.sv
hw/wb_pkg.sv
hw/if_ctrl.sv
hw/wb_fetch_master.sv
hw/fetch_buffer.sv
hw/instr_aligner.sv
hw/if_id_reg.sv
hw/if_stage.sv
verification/wb_mem_model.sv
verification/tb_if_stage.sv

/* verification/tb_if_stage.sv */
// Fetch stage testbench
`default_nettype none

module tb_if_stage;
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;
  import wb_pkg::*;

  localparam int unsigned MEM_WORDS = 1024;

  logic                    clk;
  logic                    rst_n;
  logic [31:0]             boot_addr;
  logic [31:0]             jump_target;
  logic [31:0]             branch_target;
  logic [31:0]             mepc;
  logic [MTVEC_BASE_W-1:0] mtvec_addr;
  fetch_ctrl_t             ctrl;
  logic                    id_ready;
  wb_req_t                 wb_req;
  wb_rsp_t                 wb_rsp;
  if_id_pipe_t             pipe;
  logic [31:0]             pc_if;
  logic                    if_valid;
  logic                    if_busy;
  logic                    mtvec_init;
  logic [3:0]              wait_states;
  logic [31:0]             err_lo;
  logic [31:0]             err_hi;

  // Copy of the bus model memory for the expected stream
  logic [31:0] img [MEM_WORDS];
  // Instructions taken by ID since the last redirect
  if_id_pipe_t got [$];
  // IF PC seen at each of those handshakes
  logic [31:0] got_pc [$];
  logic [31:0] lcg_state;
  logic        took;
  logic [31:0] took_pc;
  int          checks;
  int          errors;
  int          timeouts;

  if_stage if_stage_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .boot_addr_i      (boot_addr),
    .jump_target_i    (jump_target),
    .branch_target_i  (branch_target),
    .mepc_i           (mepc),
    .mtvec_addr_i     (mtvec_addr),
    .ctrl_i           (ctrl),
    .id_ready_i       (id_ready),
    .wb_rsp_i         (wb_rsp),
    .wb_req_o         (wb_req),
    .if_id_pipe_o     (pipe),
    .pc_if_o          (pc_if),
    .if_valid_o       (if_valid),
    .if_busy_o        (if_busy),
    .csr_mtvec_init_o (mtvec_init)
  );

  wb_mem_model mem_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_req_i      (wb_req),
    .wait_states_i (wait_states),
    .err_lo_i      (err_lo),
    .err_hi_i      (err_hi),
    .wb_rsp_o      (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Upper LCG bits are the better ones
  function automatic int unsigned rand_below(input int unsigned n);
    return (rand_next() >> 16) % n;
  endfunction

  // Background image of 32 bit opcodes that vary with the address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:2] ^ 30'h0005_A5A5, 2'b11};
  endfunction

  function automatic logic [15:0] parcel_at(input logic [31:0] addr);
    logic [31:0] w;
    w = img[addr[11:2]];
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic logic err_at(input logic [31:0] addr);
    logic [31:0] wa;
    wa = {addr[31:2], 2'b00};
    return (wa >= err_lo) && (wa <= err_hi);
  endfunction

  task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
    img[addr[11:2]]       = data;
    mem_i.mem[addr[11:2]] = data;
  endtask

  // Next instruction of the image at pc, by the parcel rule
  task automatic next_expected(inout logic [31:0] pc, output if_id_pipe_t exp);
    logic [15:0] first;
    first           = parcel_at(pc);
    exp.instr_valid = 1'b1;
    exp.pc          = pc;
    if (first[1:0] != 2'b11) begin
      exp.instr      = {16'h0000, first};
      exp.compressed = 1'b1;
      exp.abort_op   = err_at(pc);
      pc             = pc + 32'd2;
    end else begin
      exp.instr      = {parcel_at(pc + 32'd2), first};
      exp.compressed = 1'b0;
      exp.abort_op   = err_at(pc) | err_at(pc + 32'd2);
      pc             = pc + 32'd4;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic report_test(input string name, input int start_fails);
    $display("Test %s finished with %0d errors", name, errors + timeouts - start_fails);
  endtask

  // Records each instruction that ID accepts one cycle after the handshake
  always begin
    @(negedge clk);
    #4;
    took    = if_valid && id_ready;
    took_pc = pc_if;
    #2;
    if (took) begin
      check_value("if_id_pipe_o.instr_valid", 32'(pipe.instr_valid), 32'd1);
      got.push_back(pipe);
      got_pc.push_back(took_pc);
    end
  end

  ////////////////////////////////////////
  // Waits and stimulus
  ////////////////////////////////////////

  task automatic wait_instrs(input int n, input int limit);
    int cycles;
    cycles = 0;
    while (got.size() < n && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (got.size() < n) begin
      timeouts++;
      $display("Timeout after %0d cycles, only %0d of %0d instructions arrived",
               limit, got.size(), n);
    end
  endtask

  task automatic wait_cyc(input int limit);
    int cycles;
    cycles = 0;
    while (!wb_req.cyc && cycles < limit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!wb_req.cyc) begin
      timeouts++;
      $display("Timeout, no bus read started within %0d cycles", limit);
    end
  endtask

  // One cycle pc_set with the mtvec init pulse checked against it
  task automatic set_pc(input pc_mux_e mux, input logic [IRQ_INDEX_W-1:0] irq);
    @(negedge clk);
    ctrl.pc_set    = 1'b1;
    ctrl.pc_mux    = mux;
    ctrl.irq_index = irq;
    got.delete();
    got_pc.delete();
    #1;
    check_value("csr_mtvec_init_o", 32'(mtvec_init), 32'(mux == PC_BOOT));
    @(negedge clk);
    ctrl.pc_set = 1'b0;
    #1;
    check_value("csr_mtvec_init_o", 32'(mtvec_init), 32'd0);
  endtask

  task automatic compare_stream(input logic [31:0] start_pc, input int n);
    logic [31:0] pc;
    if_id_pipe_t exp;
    pc = start_pc;
    wait_instrs(n, 60 * n + 60);
    for (int i = 0; i < n && i < got.size(); i++) begin
      next_expected(pc, exp);
      check_value("pc_if_o", got_pc[i], exp.pc);
      check_value("if_id_pipe_o.pc", got[i].pc, exp.pc);
      check_value("if_id_pipe_o.instr", got[i].instr, exp.instr);
      check_value("if_id_pipe_o.compressed", 32'(got[i].compressed), 32'(exp.compressed));
      check_value("if_id_pipe_o.abort_op", 32'(got[i].abort_op), 32'(exp.abort_op));
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_boot();
    int start_fails;
    start_fails = errors + timeouts;
    // Quiet until the first pc_set
    repeat (4) begin
      @(negedge clk);
      check_value("wb_req_o.cyc", 32'(wb_req.cyc), 32'd0);
      check_value("wb_req_o.stb", 32'(wb_req.stb), 32'd0);
      check_value("if_busy_o", 32'(if_busy), 32'd0);
      check_value("if_valid_o", 32'(if_valid), 32'd0);
      check_value("if_id_pipe_o.instr_valid", 32'(pipe.instr_valid), 32'd0);
    end
    boot_addr = 32'h0000_0103;
    set_pc(PC_BOOT, '0);
    compare_stream(32'h0000_0100, 8);
    report_test("boot stream", start_fails);
  endtask

  task automatic test_mixed();
    int start_fails;
    start_fails = errors + timeouts;
    // c, c / 32 bit / c, straddle lo / straddle hi, c / 32 bit
    load_word(32'h0000_0200, 32'h4605_4501);
    load_word(32'h0000_0204, 32'h0010_0093);
    load_word(32'h0000_0208, 32'h0513_8082);
    load_word(32'h0000_020C, 32'h0001_00A0);
    load_word(32'h0000_0210, 32'h0020_0113);
    jump_target = 32'h0000_0200;
    set_pc(PC_JUMP, '0);
    compare_stream(32'h0000_0200, 8);
    report_test("mixed widths", start_fails);
  endtask

  // Redirect while a read is open and expect only the new stream
  task automatic redirect_case(input pc_mux_e mux, input logic [31:0] target);
    wait_states = 4'(rand_below(8));
    wait_instrs(2, 200);
    wait_cyc(100);
    set_pc(mux, '0);
    compare_stream(target, 6);
  endtask

  task automatic test_redirects();
    int start_fails;
    start_fails = errors + timeouts;
    jump_target   = 32'h0000_020A;
    branch_target = 32'h0000_0302;
    mepc          = 32'h0000_020E;
    repeat (2) begin
      redirect_case(PC_JUMP, jump_target);
      redirect_case(PC_BRANCH, branch_target);
      redirect_case(PC_MRET, mepc);
    end
    report_test("redirects", start_fails);
  endtask

  task automatic test_traps();
    int start_fails;
    logic [IRQ_INDEX_W-1:0] k;
    start_fails = errors + timeouts;
    // Base 0x400
    mtvec_addr = 25'h8;
    set_pc(PC_TRAP_EXC, '0);
    compare_stream(32'h0000_0400, 4);
    repeat (3) begin
      k = IRQ_INDEX_W'(rand_below(32));
      set_pc(PC_TRAP_IRQ, k);
      compare_stream(32'h0000_0400 + (32'(k) << 2), 4);
    end
    report_test("traps", start_fails);
  endtask

  task automatic test_backpressure();
    int start_fails;
    int cycles;
    start_fails = errors + timeouts;
    wait_states = 4'(rand_below(4));
    set_pc(PC_BOOT, '0);
    cycles = 0;
    while (got.size() < 16 && cycles < 1500) begin
      @(negedge clk);
      id_ready     = (rand_below(4) != 0);
      ctrl.halt_if = (rand_below(5) == 0);
      cycles++;
    end
    if (got.size() < 16) begin
      timeouts++;
      $display("Timeout, stream stalled under random back-pressure");
    end
    @(negedge clk);
    id_ready     = 1'b0;
    ctrl.halt_if = 1'b0;
    repeat (30) @(negedge clk);
    // Master stays off the bus while the buffer is full
    repeat (6) begin
      @(negedge clk);
      check_value("wb_req_o.cyc", 32'(wb_req.cyc), 32'd0);
      check_value("if_busy_o", 32'(if_busy), 32'd0);
    end
    id_ready = 1'b1;
    compare_stream(32'h0000_0100, 28);
    report_test("back-pressure", start_fails);
  endtask

  task automatic test_bus_error();
    int start_fails;
    start_fails = errors + timeouts;
    // c, straddle lo / straddle hi, c
    // Second word answers err
    load_word(32'h0000_0600, 32'h0513_4501);
    load_word(32'h0000_0604, 32'h4605_00A0);
    err_lo      = 32'h0000_0604;
    err_hi      = 32'h0000_0604;
    jump_target = 32'h0000_0600;
    set_pc(PC_JUMP, '0);
    compare_stream(32'h0000_0600, 6);
    err_lo = 32'hFFFF_FFFC;
    err_hi = 32'h0000_0000;
    report_test("bus error", start_fails);
  endtask

  initial begin
    lcg_state     = 32'd30;
    checks        = 0;
    errors        = 0;
    timeouts      = 0;
    took          = 1'b0;
    rst_n         = 1'b0;
    boot_addr     = '0;
    jump_target   = '0;
    branch_target = '0;
    mepc          = '0;
    mtvec_addr    = '0;
    ctrl          = '0;
    id_ready      = 1'b1;
    wait_states   = '0;
    // Empty error region
    err_lo        = 32'hFFFF_FFFC;
    err_hi        = 32'h0000_0000;
    for (int i = 0; i < MEM_WORDS; i++) begin
      load_word(32'(i) << 2, fill_word(32'(i) << 2));
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    test_boot();
    test_mixed();
    test_redirects();
    test_traps();
    test_backpressure();
    test_bus_error();

    $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/wb_mem_model.sv */
// Wishbone classic memory model
`default_nettype none

module wb_mem_model (
  input  wire             clk,
  input  wire             rst_n,
  input  wb_pkg::wb_req_t wb_req_i,
  input  logic [3:0]      wait_states_i,
  input  logic [31:0]     err_lo_i,
  input  logic [31:0]     err_hi_i,
  output wb_pkg::wb_rsp_t wb_rsp_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import wb_pkg::*;

  localparam int unsigned MEM_WORDS = 1024;

  // Word array, filled by the testbench
  logic [31:0] mem [MEM_WORDS];
  logic [3:0]  wait_cnt_q;
  logic        ack_q;
  logic        err_q;
  logic [31:0] dat_q;
  logic        req_open;
  logic        in_err;

  // Open request that has not been answered yet
  assign req_open = wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q;
  // Error region inclusive of both ends
  assign in_err   = (wb_req_i.adr >= err_lo_i) && (wb_req_i.adr <= err_hi_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt_q <= '0;
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
      dat_q      <= '0;
    end else begin
      // Answer lasts one cycle
      ack_q <= 1'b0;
      err_q <= 1'b0;
      if (req_open) begin
        if (wait_cnt_q >= wait_states_i) begin
          ack_q      <= !in_err;
          err_q      <= in_err;
          dat_q      <= mem[wb_req_i.adr[11:2]];
          wait_cnt_q <= '0;
        end else begin
          wait_cnt_q <= wait_cnt_q + 1'b1;
        end
      end
    end
  end

  assign wb_rsp_o = '{ack: ack_q, err: err_q, dat: dat_q};

endmodule

`default_nettype wire
